// ==== rtl/tile_ctrl_pkg.sv ====
// Tile control package
// Bus widths, register map, AXI response codes and the domain word layout
// shared by the AXI4-Lite front end and the register bank

package tile_ctrl_pkg;

  // Bus and register word
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Byte offsets of the two control registers
  localparam int unsigned RegRstNOffset  = 32'h0;
  localparam int unsigned RegClkEnOffset = 32'h4;

  // AXI response codes
  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespDecErr = 2'b11;

  // Returned on reads from unmapped offsets
  localparam logic [DataWidth-1:0] ErrReadData = 32'hBADC_AB1E;

  // Limits given by the register layout
  localparam int unsigned MaxClusters = 16;
  localparam int unsigned MaxMemTiles = 8;

  ////////////////////////////////////////////////////////////
  // Domain word layout
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        spu;
    logic [6:0]  reserved;
    logic [7:0]  mem_tile;
    logic [15:0] cluster;
  } domain_fields_t;

  // Written as a raw word, decoded per domain
  typedef union packed {
    logic [DataWidth-1:0] raw;
    domain_fields_t       fld;
  } domain_word_u;

endpackage

// ==== rtl/reg_port_if.sv ====
// Register access ports
// Write and read ports between the AXI4-Lite units and the register bank.
// The bank always accepts, err and rdata follow addr combinationally

`timescale 1ns/1ps

interface reg_wr_if #(
  parameter int unsigned AddrWidth = 12
);

  logic                                   req;
  logic [AddrWidth-1:0]                   addr;
  logic [tile_ctrl_pkg::DataWidth-1:0]    wdata;
  logic [tile_ctrl_pkg::StrbWidth-1:0]    wstrb;
  logic                                   err;

  modport initiator (
    output req, addr, wdata, wstrb,
    input  err
  );

  modport target (
    input  req, addr, wdata, wstrb,
    output err
  );

endinterface

interface reg_rd_if #(
  parameter int unsigned AddrWidth = 12
);

  logic                                req;
  logic [AddrWidth-1:0]                addr;
  logic [tile_ctrl_pkg::DataWidth-1:0] rdata;
  logic                                err;

  modport initiator (output req, addr, input rdata, err);

  modport target (input req, addr, output rdata, err);

endinterface

// ==== rtl/axil_wr_unit.sv ====
// AXI4-Lite write unit
// Captures AW and W independently, issues one bank write once both are
// held and returns the response on B

`timescale 1ns/1ps

module axil_wr_unit #(
  parameter int unsigned AddrWidth = 12
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic [AddrWidth-1:0]                awaddr_i,
  input  logic                                awvalid_i,
  output logic                                awready_o,
  input  logic [tile_ctrl_pkg::DataWidth-1:0] wdata_i,
  input  logic [tile_ctrl_pkg::StrbWidth-1:0] wstrb_i,
  input  logic                                wvalid_i,
  output logic                                wready_o,
  output logic [1:0]                          bresp_o,
  output logic                                bvalid_o,
  input  logic                                bready_i,
  reg_wr_if.initiator                         wr_port
);

  logic                                aw_hs, w_hs;
  logic                                aw_held_q, w_held_q;
  logic [AddrWidth-1:0]                awaddr_q;
  logic [tile_ctrl_pkg::DataWidth-1:0] wdata_q;
  logic [tile_ctrl_pkg::StrbWidth-1:0] wstrb_q;
  logic                                issue;
  logic                                bvalid_q;
  logic [1:0]                          bresp_q;

  assign awready_o = !aw_held_q && !bvalid_q;
  assign wready_o  = !w_held_q && !bvalid_q;
  assign aw_hs     = awvalid_i && awready_o;
  assign w_hs      = wvalid_i && wready_o;

  // Fire as soon as both halves are present, bypassing the capture regs
  assign issue         = (aw_held_q || aw_hs) && (w_held_q || w_hs);
  assign wr_port.req   = issue;
  assign wr_port.addr  = aw_held_q ? awaddr_q : awaddr_i;
  assign wr_port.wdata = w_held_q ? wdata_q : wdata_i;
  assign wr_port.wstrb = w_held_q ? wstrb_q : wstrb_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
      bvalid_q  <= 1'b0;
    end else begin
      aw_held_q <= !issue && (aw_held_q || aw_hs);
      w_held_q  <= !issue && (w_held_q || w_hs);
      if (issue) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) awaddr_q <= awaddr_i;
    if (w_hs) begin
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
    if (issue) bresp_q <= wr_port.err ? tile_ctrl_pkg::RespDecErr : tile_ctrl_pkg::RespOkay;
  end

  assign bvalid_o = bvalid_q;
  assign bresp_o  = bresp_q;

  a_b_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

  // One write in flight at a time
  a_no_req_with_b: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wr_port.req |-> !bvalid_q);

endmodule

// ==== rtl/axil_rd_unit.sv ====
// AXI4-Lite read unit
// Issues one bank read per AR handshake and holds R until accepted

`timescale 1ns/1ps

module axil_rd_unit #(
  parameter int unsigned AddrWidth = 12
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic [AddrWidth-1:0]                araddr_i,
  input  logic                                arvalid_i,
  output logic                                arready_o,
  output logic [tile_ctrl_pkg::DataWidth-1:0] rdata_o,
  output logic [1:0]                          rresp_o,
  output logic                                rvalid_o,
  input  logic                                rready_i,
  reg_rd_if.initiator                         rd_port
);

  logic                                ar_hs;
  logic                                rvalid_q;
  logic [tile_ctrl_pkg::DataWidth-1:0] rdata_q;
  logic [1:0]                          rresp_q;

  assign arready_o    = !rvalid_q;
  assign ar_hs        = arvalid_i && arready_o;
  assign rd_port.req  = ar_hs;
  assign rd_port.addr = araddr_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else if (ar_hs) begin
      rvalid_q <= 1'b1;
    end else if (rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  // Bank answer sampled at the handshake
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      rdata_q <= rd_port.rdata;
      rresp_q <= rd_port.err ? tile_ctrl_pkg::RespDecErr : tile_ctrl_pkg::RespOkay;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign rresp_o  = rresp_q;

  a_r_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o));

endmodule

// ==== rtl/domain_ctrl_regs.sv ====
// Domain control register bank
// RST_N and CLK_EN words with byte strobes, DECERR on unmapped offsets,
// drives reset and clock enable of clusters, memory tiles and the SPU

`timescale 1ns/1ps

module domain_ctrl_regs #(
  parameter int unsigned AddrWidth   = 12,
  parameter int unsigned NumClusters = 4,
  parameter int unsigned NumMemTiles = 2
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  reg_wr_if.target               wr_port,
  reg_rd_if.target               rd_port,
  output logic [NumClusters-1:0] cluster_rst_n_o,
  output logic [NumClusters-1:0] cluster_clk_en_o,
  output logic [NumMemTiles-1:0] mem_tile_rst_n_o,
  output logic [NumMemTiles-1:0] mem_tile_clk_en_o,
  output logic                   spu_rst_n_o,
  output logic                   spu_clk_en_o
);

  localparam int unsigned DW = tile_ctrl_pkg::DataWidth;
  localparam int unsigned WordAddrWidth = AddrWidth - 2;
  localparam logic [WordAddrWidth-1:0] RstNIdx  = WordAddrWidth'(tile_ctrl_pkg::RegRstNOffset >> 2);
  localparam logic [WordAddrWidth-1:0] ClkEnIdx = WordAddrWidth'(tile_ctrl_pkg::RegClkEnOffset >> 2);

  // Bits that exist for the configured domain counts
  localparam logic [15:0] ClusterMask = 16'((32'd1 << NumClusters) - 1);
  localparam logic [7:0]  MemTileMask = 8'((32'd1 << NumMemTiles) - 1);
  localparam logic [DW-1:0] ImplMask = {1'b1, 7'b0, MemTileMask, ClusterMask};

  tile_ctrl_pkg::domain_word_u rst_n_q, clk_en_q;
  logic wr_sel_rst, wr_sel_clk;
  logic rd_sel_rst, rd_sel_clk;

  function automatic logic [DW-1:0] merge_strb(
    input logic [DW-1:0]                       old_word,
    input logic [DW-1:0]                       new_word,
    input logic [tile_ctrl_pkg::StrbWidth-1:0] strb
  );
    logic [DW-1:0] res;
    res = old_word;
    for (int b = 0; b < tile_ctrl_pkg::StrbWidth; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return res & ImplMask;
  endfunction

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  assign wr_sel_rst  = wr_port.addr[AddrWidth-1:2] == RstNIdx;
  assign wr_sel_clk  = wr_port.addr[AddrWidth-1:2] == ClkEnIdx;
  assign wr_port.err = !(wr_sel_rst || wr_sel_clk);

  assign rd_sel_rst  = rd_port.addr[AddrWidth-1:2] == RstNIdx;
  assign rd_sel_clk  = rd_port.addr[AddrWidth-1:2] == ClkEnIdx;
  assign rd_port.err = !(rd_sel_rst || rd_sel_clk);

  assign rd_port.rdata = rd_sel_rst ? rst_n_q.raw :
                         rd_sel_clk ? clk_en_q.raw : tile_ctrl_pkg::ErrReadData;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  // All domains held in reset with clocks gated
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_n_q.raw  <= '0;
      clk_en_q.raw <= '0;
    end else if (wr_port.req) begin
      if (wr_sel_rst) rst_n_q.raw <= merge_strb(rst_n_q.raw, wr_port.wdata, wr_port.wstrb);
      if (wr_sel_clk) clk_en_q.raw <= merge_strb(clk_en_q.raw, wr_port.wdata, wr_port.wstrb);
    end
  end

  assign cluster_rst_n_o   = rst_n_q.fld.cluster[NumClusters-1:0];
  assign cluster_clk_en_o  = clk_en_q.fld.cluster[NumClusters-1:0];
  assign mem_tile_rst_n_o  = rst_n_q.fld.mem_tile[NumMemTiles-1:0];
  assign mem_tile_clk_en_o = clk_en_q.fld.mem_tile[NumMemTiles-1:0];
  assign spu_rst_n_o       = rst_n_q.fld.spu;
  assign spu_clk_en_o      = clk_en_q.fld.spu;

  a_param_limits: assert property (@(posedge clk_i)
    NumClusters inside {[1:tile_ctrl_pkg::MaxClusters]} &&
    NumMemTiles inside {[1:tile_ctrl_pkg::MaxMemTiles]});

  a_unimpl_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ((rst_n_q.raw | clk_en_q.raw) & ~ImplMask) == '0);

endmodule

// ==== rtl/tile_ctrl.sv ====
// Tile control block
// AXI4-Lite slave with reset and clock-enable registers for the
// neighbouring compute clusters, memory tiles and signal-processing unit

`timescale 1ns/1ps

module tile_ctrl #(
  parameter int unsigned NumClusters = 4,
  parameter int unsigned NumMemTiles = 2,
  parameter int unsigned AddrWidth   = 12
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  // AXI4-Lite write
  input  logic [AddrWidth-1:0]                s_axil_awaddr_i,
  input  logic                                s_axil_awvalid_i,
  output logic                                s_axil_awready_o,
  input  logic [tile_ctrl_pkg::DataWidth-1:0] s_axil_wdata_i,
  input  logic [tile_ctrl_pkg::StrbWidth-1:0] s_axil_wstrb_i,
  input  logic                                s_axil_wvalid_i,
  output logic                                s_axil_wready_o,
  output logic [1:0]                          s_axil_bresp_o,
  output logic                                s_axil_bvalid_o,
  input  logic                                s_axil_bready_i,
  // AXI4-Lite read
  input  logic [AddrWidth-1:0]                s_axil_araddr_i,
  input  logic                                s_axil_arvalid_i,
  output logic                                s_axil_arready_o,
  output logic [tile_ctrl_pkg::DataWidth-1:0] s_axil_rdata_o,
  output logic [1:0]                          s_axil_rresp_o,
  output logic                                s_axil_rvalid_o,
  input  logic                                s_axil_rready_i,
  // Domain control
  output logic [NumClusters-1:0]              cluster_rst_n_o,
  output logic [NumClusters-1:0]              cluster_clk_en_o,
  output logic [NumMemTiles-1:0]              mem_tile_rst_n_o,
  output logic [NumMemTiles-1:0]              mem_tile_clk_en_o,
  output logic                                spu_rst_n_o,
  output logic                                spu_clk_en_o
);

  reg_wr_if #(.AddrWidth(AddrWidth)) wr_bus ();
  reg_rd_if #(.AddrWidth(AddrWidth)) rd_bus ();

  ////////////////////////////////////////////////////////////
  // AXI4-Lite front end
  ////////////////////////////////////////////////////////////

  axil_wr_unit #(
    .AddrWidth(AddrWidth)
  ) i_wr_unit (
    .clk_i,
    .arst_n_i,
    .awaddr_i (s_axil_awaddr_i),
    .awvalid_i(s_axil_awvalid_i),
    .awready_o(s_axil_awready_o),
    .wdata_i  (s_axil_wdata_i),
    .wstrb_i  (s_axil_wstrb_i),
    .wvalid_i (s_axil_wvalid_i),
    .wready_o (s_axil_wready_o),
    .bresp_o  (s_axil_bresp_o),
    .bvalid_o (s_axil_bvalid_o),
    .bready_i (s_axil_bready_i),
    .wr_port  (wr_bus.initiator)
  );

  axil_rd_unit #(
    .AddrWidth(AddrWidth)
  ) i_rd_unit (
    .clk_i,
    .arst_n_i,
    .araddr_i (s_axil_araddr_i),
    .arvalid_i(s_axil_arvalid_i),
    .arready_o(s_axil_arready_o),
    .rdata_o  (s_axil_rdata_o),
    .rresp_o  (s_axil_rresp_o),
    .rvalid_o (s_axil_rvalid_o),
    .rready_i (s_axil_rready_i),
    .rd_port  (rd_bus.initiator)
  );

  ////////////////////////////////////////////////////////////
  // Register bank
  ////////////////////////////////////////////////////////////

  domain_ctrl_regs #(
    .AddrWidth  (AddrWidth),
    .NumClusters(NumClusters),
    .NumMemTiles(NumMemTiles)
  ) i_regs (
    .clk_i,
    .arst_n_i,
    .wr_port          (wr_bus.target),
    .rd_port          (rd_bus.target),
    .cluster_rst_n_o,
    .cluster_clk_en_o,
    .mem_tile_rst_n_o,
    .mem_tile_clk_en_o,
    .spu_rst_n_o,
    .spu_clk_en_o
  );

endmodule

// ==== verification/tile_ctrl_tb.sv ====
// Tile control testbench
// Drives AXI4-Lite writes and reads against a shadow register model,
// concurrent assertions compare responses and domain outputs

`timescale 1ns/1ps

module tile_ctrl_tb;

  // Implemented bits for 4 clusters, 2 memory tiles and the SPU
  localparam logic [31:0] ImplMask = 32'h8003_000F;
  localparam int unsigned NumOps = 76;
  localparam int unsigned CycleLimit = 40 * NumOps + 100;

  logic        clk;
  logic        arst_n;
  logic [11:0] awaddr;
  logic        awvalid, awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid, wready;
  logic [1:0]  bresp;
  logic        bvalid, bready;
  logic [11:0] araddr;
  logic        arvalid, arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid, rready;
  logic [3:0]  cl_rst_n, cl_clk_en;
  logic [1:0]  mt_rst_n, mt_clk_en;
  logic        spu_rst_n, spu_clk_en;

  // Shadow registers and expected responses
  logic [31:0] sh_rst, sh_clk, exp_rdata;
  logic [1:0]  exp_bresp, exp_rresp;
  logic        wr_busy;
  logic [13:0] dom_out, dom_exp;
  string       cur_test;
  int          err_cnt = 0;
  int          proc_errs = 0;
  int          test_errs0, tests_run, tests_failed;
  int          wr_cnt, wr_cnt0, b_cnt, b_cnt0;
  int unsigned cycles = 0;

  tile_ctrl #(
    .NumClusters(4),
    .NumMemTiles(2),
    .AddrWidth  (12)
  ) i_dut (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wstrb_i   (wstrb),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready),
    .cluster_rst_n_o  (cl_rst_n),
    .cluster_clk_en_o (cl_clk_en),
    .mem_tile_rst_n_o (mt_rst_n),
    .mem_tile_clk_en_o(mt_clk_en),
    .spu_rst_n_o      (spu_rst_n),
    .spu_clk_en_o     (spu_clk_en)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", CycleLimit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Values at a falling edge match the next rising edge
  always @(negedge clk) begin
    if (arst_n && bvalid && bready) b_cnt <= b_cnt + 1;
  end

  assign dom_out = {spu_rst_n, mt_rst_n, cl_rst_n, spu_clk_en, mt_clk_en, cl_clk_en};
  assign dom_exp = {sh_rst[31], sh_rst[17:16], sh_rst[3:0],
                    sh_clk[31], sh_clk[17:16], sh_clk[3:0]};

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  a_bresp: assert property (@(posedge clk) disable iff (!arst_n)
    bvalid && bready |-> bresp == exp_bresp)
    else begin
      $display("** Error [%s] bresp: expected %0d, actual %0d",
               cur_test, $sampled(exp_bresp), $sampled(bresp));
      err_cnt++;
    end

  a_read: assert property (@(posedge clk) disable iff (!arst_n)
    rvalid && rready |-> rdata == exp_rdata && rresp == exp_rresp)
    else begin
      $display("** Error [%s] read data/resp: expected %h/%0d, actual %h/%0d", cur_test,
               $sampled(exp_rdata), $sampled(exp_rresp), $sampled(rdata), $sampled(rresp));
      err_cnt++;
    end

  a_domains: assert property (@(posedge clk) disable iff (!arst_n)
    !wr_busy |-> dom_out == dom_exp)
    else begin
      $display("** Error [%s] domain outputs: expected %h, actual %h",
               cur_test, $sampled(dom_exp), $sampled(dom_out));
      err_cnt++;
    end

  a_b_hold: assert property (@(posedge clk) disable iff (!arst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      $display("[%s] B response dropped or changed before bready", cur_test);
      err_cnt++;
    end

  a_r_hold: assert property (@(posedge clk) disable iff (!arst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      $display("[%s] R response dropped or changed before rready", cur_test);
      err_cnt++;
    end

  a_one_write: assert property (@(posedge clk) disable iff (!arst_n)
    bvalid |-> !awready && !wready)
    else begin
      $display("[%s] AW or W ready raised while a B response was pending", cur_test);
      err_cnt++;
    end

  a_one_read: assert property (@(posedge clk) disable iff (!arst_n)
    rvalid |-> !arready)
    else begin
      $display("[%s] AR ready raised while an R response was pending", cur_test);
      err_cnt++;
    end

  ////////////////////////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return ((old & ~mask) | (data & mask)) & ImplMask;
  endfunction

  task automatic send_aw(input logic [11:0] addr, input int dly);
    repeat (dly) @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    @(posedge clk);
    awvalid <= 1'b0;
  endtask

  task automatic send_w(input logic [31:0] data, input logic [3:0] strb, input int dly);
    repeat (dly) @(posedge clk);
    wdata  <= data;
    wstrb  <= strb;
    wvalid <= 1'b1;
    @(negedge clk);
    while (!wready) @(negedge clk);
    @(posedge clk);
    wvalid <= 1'b0;
  endtask

  // Positive skew sends AW first, negative sends W first
  task automatic write_word(input logic [11:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int skew, input int b_dly);
    wr_busy   = 1'b1;
    exp_bresp = (addr == 12'h0 || addr == 12'h4) ? tile_ctrl_pkg::RespOkay
                                                 : tile_ctrl_pkg::RespDecErr;
    fork
      send_aw(addr, (skew < 0) ? -skew : 0);
      send_w(data, strb, (skew > 0) ? skew : 0);
    join
    repeat (b_dly) @(posedge clk);
    bready <= 1'b1;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    @(posedge clk);
    bready <= 1'b0;
    wr_cnt++;
    if (addr == 12'h0) sh_rst = merge_bytes(sh_rst, data, strb);
    if (addr == 12'h4) sh_clk = merge_bytes(sh_clk, data, strb);
    wr_busy = 1'b0;
  endtask

  task automatic read_word(input logic [11:0] addr, input int r_dly);
    if (addr == 12'h0) exp_rdata = sh_rst;
    else if (addr == 12'h4) exp_rdata = sh_clk;
    else exp_rdata = tile_ctrl_pkg::ErrReadData;
    exp_rresp = (addr == 12'h0 || addr == 12'h4) ? tile_ctrl_pkg::RespOkay
                                                 : tile_ctrl_pkg::RespDecErr;
    araddr  <= addr;
    arvalid <= 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
    repeat (r_dly) @(posedge clk);
    rready <= 1'b1;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic begin_test(input string name);
    cur_test   = name;
    test_errs0 = err_cnt + proc_errs;
    wr_cnt0    = wr_cnt;
    b_cnt0     = b_cnt;
  endtask

  task automatic close_test();
    int errs;
    @(negedge clk);
    assert (b_cnt - b_cnt0 == wr_cnt - wr_cnt0)
      else begin
        $display("** Error [%s] B count: expected %0d, actual %0d",
                 cur_test, wr_cnt - wr_cnt0, b_cnt - b_cnt0);
        proc_errs++;
      end
    errs = err_cnt + proc_errs - test_errs0;
    $display("Test %s finished with %0d errors", cur_test, errs);
    tests_run++;
    if (errs != 0) tests_failed++;
    @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic full_word_rw();
    begin_test("full_word_rw");
    for (int i = 0; i < 8; i++) begin
      write_word((i % 2 != 0) ? 12'h4 : 12'h0, $urandom, 4'hF, 0, 0);
      read_word((i % 2 != 0) ? 12'h4 : 12'h0, 0);
    end
    close_test();
  endtask

  task automatic byte_strobes();
    logic [11:0] a;
    begin_test("byte_strobes");
    for (int i = 0; i < 8; i++) begin
      a = ($urandom % 2 != 0) ? 12'h4 : 12'h0;
      write_word(a, $urandom, 4'($urandom), 0, 0);
      read_word(a, 0);
    end
    close_test();
  endtask

  task automatic unmapped_access();
    logic [11:0] a;
    begin_test("unmapped_access");
    for (int i = 0; i < 4; i++) begin
      a = 12'h8 + 12'($urandom % 4088);
      write_word(a, $urandom, 4'hF, 0, 0);
      read_word(a, 0);
      read_word(12'h0, 0);
      read_word(12'h4, 0);
    end
    close_test();
  endtask

  task automatic channel_ordering();
    begin_test("channel_ordering");
    for (int i = 0; i < 12; i++) begin
      write_word(($urandom % 2 != 0) ? 12'h4 : 12'h0, $urandom, 4'($urandom),
                 int'($urandom % 9) - 4, int'($urandom % 7));
    end
    read_word(12'h0, 0);
    read_word(12'h4, 0);
    close_test();
  endtask

  // Read of the same register returns the value from before the write
  // Even rounds put AW, W and AR on the same edge
  task automatic concurrent_rw();
    logic [11:0] a;
    begin_test("concurrent_rw");
    for (int i = 0; i < 6; i++) begin
      a = ($urandom % 2 != 0) ? 12'h4 : 12'h0;
      fork
        write_word(a, $urandom, 4'($urandom), (i % 2 == 0) ? 0 : int'($urandom % 4),
                   int'($urandom % 4));
        read_word(a, 1 + int'($urandom % 5));
      join
    end
    close_test();
  endtask

  initial begin
    arst_n    = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    sh_rst    = '0;
    sh_clk    = '0;
    exp_rdata = '0;
    exp_bresp = '0;
    exp_rresp = '0;
    wr_busy   = 1'b0;
    cur_test  = "reset_state";
    void'($urandom(81));
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);

    begin_test("reset_state");
    read_word(12'h0, 0);
    read_word(12'h4, 0);
    close_test();
    full_word_rw();
    byte_strobes();
    unmapped_access();
    channel_ordering();
    concurrent_rw();

    repeat (2) @(posedge clk);
    $display("Tests run: %0d, failed: %0d, errors: %0d",
             tests_run, tests_failed, err_cnt + proc_errs);
    if (err_cnt + proc_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== list.f ====
rtl/tile_ctrl_pkg.sv
rtl/reg_port_if.sv
rtl/axil_wr_unit.sv
rtl/axil_rd_unit.sv
rtl/domain_ctrl_regs.sv
rtl/tile_ctrl.sv
verification/tile_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the tile control testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tile_ctrl_tb \
  -f list.f \
  -o sim_tile_ctrl

./obj_dir/sim_tile_ctrl | tee sim.log

if grep -qx "PASS: all tests" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
